//--- include/rename_defs.svh
// Rename core sizing
// Register counts, physical tag count, ROB depth and the widths they imply

`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Architectural register file as seen by the program
`define RENAME_ARCH_REGS 16
`define RENAME_ARCH_W    4

// Physical tags shared by the map table and the free list
`define RENAME_PHYS_REGS 32
`define RENAME_PHYS_W    5

// Reorder buffer slots, one per in-flight instruction
`define RENAME_ROB_DEPTH 8
`define RENAME_ROB_W     3

// Widths must satisfy 2**W == count for every pair above

`endif

//--- run.sh
#!/bin/sh
# Build the rename core testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module rename_tb -o rename_sim \
    || { echo "Verilator build did not complete"; exit 1; }
./obj_dir/rename_sim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

//--- source/dispatch_ctrl.sv
// Dispatch controller
// Runs the four-phase req/ack handshake for one lane, grants only when the
// ROB and the free list can take the instruction, and strobes allocation

`timescale 1ns/1ns

module dispatch_ctrl (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      req,
    input  rename_pkg::dispatch_req_t data,
    input  logic                      rob_full,
    input  logic                      free_empty,
    output logic                      ack,
    output logic                      alloc,
    output logic                      alloc_uses_rd
);
    import rename_pkg::*;

    dispatch_state_t state;
    dispatch_state_t state_next;
    logic            resources_ok;

    // Register zero is never renamed, so it counts as no destination
    assign alloc_uses_rd = data.uses_rd && (data.arch_rd != '0);

    // A tag is only needed when there is a real destination
    assign resources_ok = !rob_full && !(alloc_uses_rd && free_empty);

    ////////////////////////////////////////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            // Wait here under back-pressure, ack stays low
            IDLE: if (req && resources_ok) state_next = GRANT;
            // One cycle of allocation, then hold ack until req drops
            GRANT: state_next = req ? RELEASE : IDLE;
            RELEASE: if (!req) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Alloc is a single-cycle strobe, GRANT lasts exactly one cycle
    assign alloc = (state == GRANT);
    assign ack   = (state == GRANT) || (state == RELEASE);

endmodule

//--- source/free_list.sv
// Free list
// Circular queue of unused physical tags, popped from the front on rename
// and refilled at the back as instructions retire

`timescale 1ns/1ns
`include "rename_defs.svh"

module free_list (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  pop,
    input  logic                  push,
    input  rename_pkg::phys_tag_t push_tag,
    output rename_pkg::phys_tag_t head_tag,
    output logic                  empty
);
    import rename_pkg::*;

    phys_tag_t                slot_q [`RENAME_PHYS_REGS];
    logic [`RENAME_PHYS_W-1:0] rd_ptr;
    logic [`RENAME_PHYS_W-1:0] wr_ptr;
    free_count_t              count;

    ////////////////////////////////////////////////////////////////////////////
    // Queue storage
    ////////////////////////////////////////////////////////////////////////////

    // Starts holding the tags above the identity map, ascending from the front
    // Slots past the first sixteen get values that are never read
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RENAME_PHYS_REGS; i++) begin
                slot_q[i] <= phys_tag_t'(i + `RENAME_ARCH_REGS);
            end
        end else if (push) begin
            slot_q[wr_ptr] <= push_tag;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= `RENAME_PHYS_W'(`RENAME_PHYS_REGS - `RENAME_ARCH_REGS);
            count  <= free_count_t'(`RENAME_PHYS_REGS - `RENAME_ARCH_REGS);
        end else begin
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push) wr_ptr <= wr_ptr + 1'b1;
            // Pop and push in one cycle cancel out
            case ({pop, push})
                2'b10:   count <= count - free_count_t'(1);
                2'b01:   count <= count + free_count_t'(1);
                default: count <= count;
            endcase
        end
    end

    assign head_tag = slot_q[rd_ptr];
    assign empty    = (count == '0);

endmodule

//--- source/map_table.sv
// Speculative map table
// Maps each architectural register to its newest physical tag, reads the
// current tag for the destination and installs the new one on write

`timescale 1ns/1ns
`include "rename_defs.svh"

module map_table (
    input  logic                  clock,
    input  logic                  rst_n,
    input  rename_pkg::arch_reg_t arch_rd,
    input  logic                  write,
    input  rename_pkg::phys_tag_t new_tag,
    output rename_pkg::phys_tag_t old_tag
);
    import rename_pkg::*;

    phys_tag_t map_q [`RENAME_ARCH_REGS];

    ////////////////////////////////////////////////////////////////////////////
    // Mapping registers
    ////////////////////////////////////////////////////////////////////////////

    // Identity after reset, register i lives in tag i
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (write) begin
            map_q[arch_rd] <= new_tag;
        end
    end

    // Previous tag goes into the ROB entry, freed when this instruction commits
    assign old_tag = map_q[arch_rd];

endmodule

//--- source/rename_core.sv
// Rename and retire core
// One dispatch lane through the map table, free list and reorder buffer,
// with out-of-order completion and in-order commit

`timescale 1ns/1ns

module rename_core (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      dispatch_req,
    input  rename_pkg::dispatch_req_t dispatch_data,
    input  rename_pkg::complete_t     complete,
    output logic                      dispatch_ack,
    output rename_pkg::rob_idx_t      dispatch_idx,
    output rename_pkg::commit_t       commit
);
    import rename_pkg::*;

    logic       alloc;
    logic       alloc_uses_rd;
    logic       retire;
    logic       rob_full;
    logic       free_empty;
    rob_idx_t   rob_head;
    rob_idx_t   rob_tail;
    rob_count_t rob_count;
    phys_tag_t  free_tag;
    phys_tag_t  prev_tag;
    rob_entry_t alloc_entry;
    rob_entry_t retire_entry;

    ////////////////////////////////////////////////////////////////////////////
    // Dispatch side
    ////////////////////////////////////////////////////////////////////////////

    dispatch_ctrl u_dispatch_ctrl (
        .clock         (clock),
        .rst_n         (rst_n),
        .req           (dispatch_req),
        .data          (dispatch_data),
        .rob_full      (rob_full),
        .free_empty    (free_empty),
        .ack           (dispatch_ack),
        .alloc         (alloc),
        .alloc_uses_rd (alloc_uses_rd)
    );

    // Tags are zero for instructions without a destination
    always_comb begin
        alloc_entry.arch_rd = dispatch_data.arch_rd;
        alloc_entry.uses_rd = alloc_uses_rd;
        alloc_entry.new_tag = alloc_uses_rd ? free_tag : '0;
        alloc_entry.old_tag = alloc_uses_rd ? prev_tag : '0;
    end

    // Tail has moved on after GRANT, so ack holds the slot just written
    assign dispatch_idx = alloc ? rob_tail : rob_tail - rob_idx_t'(1);

    map_table u_map_table (
        .clock   (clock),
        .rst_n   (rst_n),
        .arch_rd (dispatch_data.arch_rd),
        .write   (alloc && alloc_uses_rd),
        .new_tag (free_tag),
        .old_tag (prev_tag)
    );

    // Retiring instruction hands back the tag it overwrote
    free_list u_free_list (
        .clock    (clock),
        .rst_n    (rst_n),
        .pop      (alloc && alloc_uses_rd),
        .push     (retire && retire_entry.uses_rd),
        .push_tag (retire_entry.old_tag),
        .head_tag (free_tag),
        .empty    (free_empty)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reorder buffer
    ////////////////////////////////////////////////////////////////////////////

    rob_pointers u_rob_pointers (
        .clock  (clock),
        .rst_n  (rst_n),
        .alloc  (alloc),
        .retire (retire),
        .head   (rob_head),
        .tail   (rob_tail),
        .count  (rob_count),
        .full   (rob_full)
    );

    rob_storage u_rob_storage (
        .clock        (clock),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .tail         (rob_tail),
        .head         (rob_head),
        .entry        (alloc_entry),
        .complete     (complete),
        .retire       (retire),
        .retire_entry (retire_entry),
        .commit       (commit)
    );

endmodule

//--- source/rename_pkg.sv
// Rename core types
// Index vectors, the packets passed between blocks and the dispatch FSM states

`include "rename_defs.svh"

package rename_pkg;

    // Plain index and count vectors
    typedef logic [`RENAME_ARCH_W-1:0] arch_reg_t;
    typedef logic [`RENAME_PHYS_W-1:0] phys_tag_t;
    typedef logic [`RENAME_ROB_W-1:0]  rob_idx_t;
    // One extra bit so that a full structure can be counted
    typedef logic [`RENAME_ROB_W:0]    rob_count_t;
    typedef logic [`RENAME_PHYS_W:0]   free_count_t;

    // Instruction offered on the dispatch handshake
    typedef struct packed {
        arch_reg_t arch_rd;
        logic      uses_rd;
    } dispatch_req_t;

    // Contents of one ROB slot
    typedef struct packed {
        arch_reg_t arch_rd;
        logic      uses_rd;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
    } rob_entry_t;

    // Completion report for one slot
    typedef struct packed {
        logic     valid;
        rob_idx_t idx;
    } complete_t;

    // Registered commit packet, program order
    typedef struct packed {
        logic      valid;
        arch_reg_t arch_rd;
        logic      uses_rd;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
        rob_idx_t  idx;
    } commit_t;

    typedef enum logic [1:0] {IDLE, GRANT, RELEASE} dispatch_state_t;

endpackage

//--- source/rob_pointers.sv
// ROB pointers
// Head and tail slot counters plus the occupancy count of the reorder buffer

`timescale 1ns/1ns
`include "rename_defs.svh"

module rob_pointers (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   alloc,
    input  logic                   retire,
    output rename_pkg::rob_idx_t   head,
    output rename_pkg::rob_idx_t   tail,
    output rename_pkg::rob_count_t count,
    output logic                   full
);
    import rename_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Slot counters
    ////////////////////////////////////////////////////////////////////////////

    // Depth is a power of two, so the counters wrap on their own
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (alloc) tail <= tail + rob_idx_t'(1);
            if (retire) head <= head + rob_idx_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////////////////////////////////////////

    // Alloc and retire together leave the count where it is
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({alloc, retire})
                2'b10:   count <= count + rob_count_t'(1);
                2'b01:   count <= count - rob_count_t'(1);
                default: count <= count;
            endcase
        end
    end

    assign full = (count == rob_count_t'(`RENAME_ROB_DEPTH));

endmodule

//--- source/rob_storage.sv
// ROB storage
// Holds the in-flight entries with valid and complete flags, retires the head
// in program order and registers the commit packet

`timescale 1ns/1ns
`include "rename_defs.svh"

module rob_storage (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   alloc,
    input  rename_pkg::rob_idx_t   tail,
    input  rename_pkg::rob_idx_t   head,
    input  rename_pkg::rob_entry_t entry,
    input  rename_pkg::complete_t  complete,
    output logic                   retire,
    output rename_pkg::rob_entry_t retire_entry,
    output rename_pkg::commit_t    commit
);
    import rename_pkg::*;

    rob_entry_t                   entry_mem [`RENAME_ROB_DEPTH];
    logic [`RENAME_ROB_DEPTH-1:0] busy;
    logic [`RENAME_ROB_DEPTH-1:0] done;
    logic                         commit_valid_q;
    rob_entry_t                   commit_entry_q;
    rob_idx_t                     commit_idx_q;

    // Payload only, flags below say whether a slot means anything
    always_ff @(posedge clock) begin
        if (alloc) entry_mem[tail] <= entry;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slot flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            done <= '0;
        end else begin
            if (retire) busy[head] <= 1'b0;
            // Repeated completion of a finished slot changes nothing
            if (complete.valid && busy[complete.idx]) done[complete.idx] <= 1'b1;
            if (alloc) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
            end
        end
    end

    // Head retires once it is both occupied and finished
    assign retire       = busy[head] && done[head];
    assign retire_entry = entry_mem[head];

    // Commit pulse lands on the same edge that moves the head
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) commit_valid_q <= 1'b0;
        else commit_valid_q <= retire;
    end

    always_ff @(posedge clock) begin
        commit_entry_q <= retire_entry;
        commit_idx_q   <= head;
    end

    always_comb begin
        commit.valid   = commit_valid_q;
        commit.arch_rd = commit_entry_q.arch_rd;
        commit.uses_rd = commit_entry_q.uses_rd;
        commit.new_tag = commit_entry_q.new_tag;
        commit.old_tag = commit_entry_q.old_tag;
        commit.idx     = commit_idx_q;
    end

endmodule

//--- tb.f
+incdir+include
source/rename_pkg.sv
source/dispatch_ctrl.sv
source/rob_pointers.sv
source/rob_storage.sv
source/map_table.sv
source/free_list.sv
source/rename_core.sv
tests/rename_properties.sv
tests/rename_checker.sv
tests/rename_tb.sv

//--- tests/rename_checker.sv
// Rename checker
// Reference model of the map table and free list that predicts every
// commit packet and watches the dispatch handshake

`timescale 1ns/1ns
`include "rename_defs.svh"

module rename_checker (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      dispatch_req,
    input  rename_pkg::dispatch_req_t dispatch_data,
    input  logic                      dispatch_ack,
    input  rename_pkg::rob_idx_t      dispatch_idx,
    input  rename_pkg::commit_t       commit,
    output int                        error_count,
    output int                        open_count
);
    import rename_pkg::*;

    // Predicted commits in program order
    commit_t     expect_q[$];
    phys_tag_t   free_q[$];
    phys_tag_t   map_model [`RENAME_ARCH_REGS];
    int unsigned seq;
    int unsigned req_rises;
    int unsigned ack_rises;
    logic        req_prev;
    logic        ack_prev;

    initial error_count = 0;

    task automatic compare_field(input string name, input int unsigned expected,
                                 input int unsigned actual);
        if (expected != actual) begin
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model, sampled on the falling edge where every DUT output is settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        commit_t exp;
        if (!rst_n) begin
            // Identity map, tags 16 to 31 free in ascending order
            expect_q.delete();
            free_q.delete();
            for (int i = 0; i < `RENAME_ARCH_REGS; i++) map_model[i] = phys_tag_t'(i);
            for (int t = `RENAME_ARCH_REGS; t < `RENAME_PHYS_REGS; t++) begin
                free_q.push_back(phys_tag_t'(t));
            end
            seq       = 0;
            req_rises = 0;
            ack_rises = 0;
            req_prev  = 1'b0;
            ack_prev  = 1'b0;
        end else begin
            // Commits first, a tag freed on the retire edge is already back
            if (commit.valid) begin
                if (expect_q.size() == 0) begin
                    $display("Commit at %0t ns with no dispatched instruction to match", $time);
                    error_count++;
                end else begin
                    exp = expect_q.pop_front();
                    compare_field("commit.idx", 32'(exp.idx), 32'(commit.idx));
                    compare_field("commit.arch_rd", 32'(exp.arch_rd), 32'(commit.arch_rd));
                    compare_field("commit.uses_rd", 32'(exp.uses_rd), 32'(commit.uses_rd));
                    // Tags carry no meaning without a destination
                    if (exp.uses_rd) begin
                        compare_field("commit.new_tag", 32'(exp.new_tag), 32'(commit.new_tag));
                        compare_field("commit.old_tag", 32'(exp.old_tag), 32'(commit.old_tag));
                        free_q.push_back(exp.old_tag);
                    end
                end
            end
            if (dispatch_req && !req_prev) req_rises++;
            if (dispatch_ack && !ack_prev) begin
                ack_rises++;
                if (!dispatch_req || !req_prev) begin
                    $display("Ack rose at %0t ns with no req held before it", $time);
                    error_count++;
                end
                if (ack_rises != req_rises) begin
                    $display("Ack count %0d does not match req count %0d at %0t ns",
                             ack_rises, req_rises, $time);
                    error_count++;
                end
                // Register zero never takes a tag
                exp.valid   = 1'b1;
                exp.arch_rd = dispatch_data.arch_rd;
                exp.uses_rd = dispatch_data.uses_rd && (dispatch_data.arch_rd != '0);
                exp.new_tag = '0;
                exp.old_tag = '0;
                exp.idx     = rob_idx_t'(seq % `RENAME_ROB_DEPTH);
                if (exp.uses_rd) begin
                    if (free_q.size() == 0) begin
                        $display("Dispatch at %0t ns granted with no free tag left", $time);
                        error_count++;
                    end else begin
                        exp.new_tag = free_q.pop_front();
                        exp.old_tag = map_model[exp.arch_rd];
                        map_model[exp.arch_rd] = exp.new_tag;
                    end
                end
                compare_field("dispatch_idx", 32'(exp.idx), 32'(dispatch_idx));
                expect_q.push_back(exp);
                seq++;
            end
            req_prev = dispatch_req;
            ack_prev = dispatch_ack;
        end
        open_count = expect_q.size();
    end

endmodule

//--- tests/rename_properties.sv
// Rename core assertions
// Handshake and ROB counter rules checked on the core's own signals

`timescale 1ns/1ns
`include "rename_defs.svh"

module rename_properties (
    input logic                   clock,
    input logic                   rst_n,
    input logic                   dispatch_req,
    input logic                   dispatch_ack,
    input logic                   alloc,
    input logic                   retire,
    input rename_pkg::rob_count_t rob_count
);
    import rename_pkg::*;

    // Ack only rises in answer to a req that is still up
    ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(dispatch_ack) |-> dispatch_req)
        else $error("dispatch ack rose while req was low");

    // Ack holds for as long as req does
    ack_holds: assert property (@(posedge clock) disable iff (!rst_n)
        dispatch_ack && dispatch_req |=> dispatch_ack)
        else $error("dispatch ack dropped before req");

    alloc_single: assert property (@(posedge clock) disable iff (!rst_n)
        alloc |=> !alloc)
        else $error("alloc strobe longer than one cycle");

    alloc_not_full: assert property (@(posedge clock) disable iff (!rst_n)
        alloc |-> dispatch_ack && rob_count < rob_count_t'(`RENAME_ROB_DEPTH))
        else $error("allocation into a full ROB or without ack");

    count_bound: assert property (@(posedge clock) disable iff (!rst_n)
        rob_count <= rob_count_t'(`RENAME_ROB_DEPTH) && (retire -> rob_count != '0))
        else $error("ROB occupancy out of range");

endmodule

bind rename_core rename_properties u_rename_properties (
    .clock        (clock),
    .rst_n        (rst_n),
    .dispatch_req (dispatch_req),
    .dispatch_ack (dispatch_ack),
    .alloc        (alloc),
    .retire       (retire),
    .rob_count    (rob_count)
);

//--- tests/rename_tb.sv
// Rename core testbench
// Clock and reset source, LFSR driven dispatch and completion stimulus,
// a watchdog and the closing summary

`timescale 1ns/1ns
`include "rename_defs.svh"

module rename_clock (
    output logic clock,
    output logic rst_n
);
    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Reset held low for three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
    end
endmodule

module rename_tb;
    import rename_pkg::*;

    localparam int          total_instr      = 256;
    localparam int          cycles_per_instr = 40;
    localparam logic [15:0] lfsr_seed        = 16'd55498;

    logic          clock;
    logic          rst_n;
    logic          dispatch_req;
    dispatch_req_t dispatch_data;
    complete_t     complete;
    logic          dispatch_ack;
    rob_idx_t      dispatch_idx;
    commit_t       commit;
    int            checker_errors;
    int            open_count;

    logic [15:0] lfsr_state = lfsr_seed;
    // Slots that are dispatched and not yet reported complete
    rob_idx_t    pending[$];
    logic        hold_completions;
    int          tb_errors    = 0;
    int          tests_failed = 0;
    int          n_dispatched = 0;
    int          n_commits    = 0;
    commit_t     last_commit;

    rename_clock u_rename_clock (
        .clock (clock),
        .rst_n (rst_n)
    );

    rename_core u_rename_core (
        .clock         (clock),
        .rst_n         (rst_n),
        .dispatch_req  (dispatch_req),
        .dispatch_data (dispatch_data),
        .complete      (complete),
        .dispatch_ack  (dispatch_ack),
        .dispatch_idx  (dispatch_idx),
        .commit        (commit)
    );

    rename_checker u_rename_checker (
        .clock         (clock),
        .rst_n         (rst_n),
        .dispatch_req  (dispatch_req),
        .dispatch_data (dispatch_data),
        .dispatch_ack  (dispatch_ack),
        .dispatch_idx  (dispatch_idx),
        .commit        (commit),
        .error_count   (checker_errors),
        .open_count    (open_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////////////////////

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // One LFSR step per bit handed out
    function automatic int unsigned take_bits(input int count);
        int unsigned value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | 32'(lfsr_state[0]);
        end
        return value;
    endfunction

    // Sparse mode favours register zero and instructions without a destination
    function automatic dispatch_req_t random_instr(input logic sparse);
        dispatch_req_t instr;
        instr.arch_rd = arch_reg_t'(take_bits(`RENAME_ARCH_W));
        if (sparse && take_bits(1) == 1) instr.arch_rd = '0;
        instr.uses_rd = sparse ? (take_bits(1) == 1) : (take_bits(2) != 0);
        return instr;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Drivers and helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input int unsigned expected,
                               input int unsigned actual);
        if (expected != actual) begin
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            tb_errors++;
        end
    endtask

    // Full four-phase cycle
    // A nonzero stall_cycles first expects back-pressure and then a commit
    task automatic dispatch_one(input dispatch_req_t instr, input int stall_cycles);
        int commits_before;
        commits_before = n_commits;
        @(posedge clock);
        dispatch_req  <= 1'b1;
        dispatch_data <= instr;
        if (stall_cycles > 0) begin
            repeat (stall_cycles) begin
                @(negedge clock);
                if (dispatch_ack) begin
                    $display("Dispatch %0d got ack at %0t ns while the ROB was full",
                             n_dispatched, $time);
                    tb_errors++;
                end
            end
            // Let completions drain the ROB so the waiting req can go
            hold_completions = 1'b0;
        end
        @(negedge clock);
        while (!dispatch_ack) @(negedge clock);
        if (stall_cycles > 0 && n_commits == commits_before) begin
            $display("Dispatch %0d got ack at %0t ns before any commit freed the ROB",
                     n_dispatched, $time);
            tb_errors++;
        end
        pending.push_back(dispatch_idx);
        n_dispatched++;
        @(posedge clock);
        dispatch_req <= 1'b0;
        @(negedge clock);
        while (dispatch_ack) @(negedge clock);
    endtask

    // The extra rising edge lets every falling-edge check of the last commit finish
    task automatic drain();
        while (n_commits != n_dispatched) @(negedge clock);
        @(posedge clock);
    endtask

    task automatic finish_test(input string name, input int instrs, input int errors_before);
        int errors;
        errors = tb_errors + checker_errors - errors_before;
        if (errors != 0) tests_failed++;
        $display("Test %s: %0d instructions, %0d errors", name, instrs, errors);
    endtask

    // Completes a random in-flight slot so that reports come out of order
    always @(posedge clock) begin
        int pick;
        complete <= '0;
        if (rst_n && !hold_completions && pending.size() > 0) begin
            if (take_bits(2) != 0) begin
                pick = int'(take_bits(3)) % pending.size();
                complete.valid <= 1'b1;
                complete.idx   <= pending[pick];
                pending.delete(pick);
            end
        end
    end

    // Commit is a one-cycle pulse that the falling edge sees once
    always @(negedge clock) begin
        if (rst_n && commit.valid) begin
            last_commit = commit;
            n_commits++;
        end
    end

    // Watchdog
    initial begin
        repeat (total_instr * cycles_per_instr) @(posedge clock);
        $display("Timeout after %0d cycles, the DUT stopped making progress",
                 total_instr * cycles_per_instr);
        $display("Regression failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int            errors_before;
        dispatch_req_t instr;
        dispatch_req     = 1'b0;
        dispatch_data    = '0;
        complete         = '0;
        hold_completions = 1'b0;
        @(posedge rst_n);
        @(negedge clock);

        // Idle outputs and then one rename straight from the identity map
        errors_before = tb_errors + checker_errors;
        check_value("dispatch_ack", 0, 32'(dispatch_ack));
        check_value("commit.valid", 0, 32'(commit.valid));
        instr.arch_rd = arch_reg_t'(take_bits(`RENAME_ARCH_W));
        if (instr.arch_rd == '0) instr.arch_rd = arch_reg_t'(1);
        instr.uses_rd = 1'b1;
        dispatch_one(instr, 0);
        drain();
        check_value("commit.new_tag", `RENAME_ARCH_REGS, 32'(last_commit.new_tag));
        check_value("commit.old_tag", 32'(instr.arch_rd), 32'(last_commit.old_tag));
        finish_test("reset", 1, errors_before);

        errors_before = tb_errors + checker_errors;
        repeat (200) dispatch_one(random_instr(1'b0), 0);
        drain();
        finish_test("renaming", 200, errors_before);

        // Tag reuse after these shows whether a tag leaked back
        errors_before = tb_errors + checker_errors;
        repeat (40) dispatch_one(random_instr(1'b1), 0);
        drain();
        finish_test("no_destination", 40, errors_before);

        // Batch completed in random order once all six are in flight
        errors_before = tb_errors + checker_errors;
        hold_completions = 1'b1;
        repeat (6) dispatch_one(random_instr(1'b0), 0);
        hold_completions = 1'b0;
        drain();
        finish_test("out_of_order", 6, errors_before);

        // Eight fill the ROB and the ninth must wait for a commit
        errors_before = tb_errors + checker_errors;
        hold_completions = 1'b1;
        repeat (8) dispatch_one(random_instr(1'b0), 0);
        dispatch_one(random_instr(1'b0), 12);
        drain();
        repeat (10) @(posedge clock);
        check_value("commit count", n_dispatched, n_commits);
        if (open_count != 0) begin
            $display("Checker still holds %0d dispatches with no commit", open_count);
            tb_errors++;
        end
        finish_test("back_pressure", 9, errors_before);

        $display("Tests run 5, tests with errors %0d, instructions %0d, errors %0d",
                 tests_failed, n_dispatched, tb_errors + checker_errors);
        if (tests_failed == 0 && tb_errors + checker_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
